/* src/sys_bus_pkg.sv */
/*
  system bus types shared by the decoder and its slaves
  one access in flight, the master holds addr and wdata until ack
  byte select is carried but no slave looks at it
*/
`default_nettype none

package sys_bus_pkg;

  // request from the bus master
  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // write data
    logic [3:0]  sel;    // byte select
    logic        wen;    // write enable pulse
    logic        ren;    // read enable pulse
  } sys_req_t;

  // response back to the master
  typedef struct packed {
    logic [31:0] rdata;  // valid with ack
    logic        err;    // unmapped offset
    logic        ack;
  } sys_rsp_t;

  ////////////////////////////////////////
  // region map
  ////////////////////////////////////////
  localparam int unsigned SYS_REGIONS = 8;
  localparam int unsigned REGION_MSB  = 22;
  localparam int unsigned REGION_LSB  = 20;

  typedef logic [REGION_MSB-REGION_LSB:0] region_t;
  typedef logic [REGION_LSB-1:0]          offset_t;  // address inside a region

  localparam region_t HK_REGION     = 3'd0;
  localparam region_t ROUTER_REGION = 3'd3;

  // housekeeping offsets
  localparam offset_t HK_ID_ADDR   = 'h00;
  localparam offset_t HK_LOOP_ADDR = 'h04;
  localparam offset_t HK_LED_ADDR  = 'h08;

  // router offsets, channel b sits 0x10 above channel a
  localparam offset_t RT_CFG_A_ADDR    = 'h00;
  localparam offset_t RT_STATIC_A_ADDR = 'h04;
  localparam offset_t RT_OFFSET_A_ADDR = 'h08;
  localparam offset_t RT_CFG_B_ADDR    = 'h10;
  localparam offset_t RT_STATIC_B_ADDR = 'h14;
  localparam offset_t RT_OFFSET_B_ADDR = 'h18;

endpackage

`default_nettype wire

/* src/analog_pkg.sv */
/*
  sample and converter code types for the analog path
  converter codes are unsigned with negative slope, samples are two's complement
  only the upper 14 bits of the converter are used
*/
`default_nettype none

package analog_pkg;

  localparam int unsigned ADC_BITS = 14;

  typedef logic signed [ADC_BITS-1:0] sample_t;    // two's complement sample
  typedef logic        [ADC_BITS-1:0] adc_code_t;  // raw converter code

  // both channels side by side
  typedef struct packed {
    sample_t a;
    sample_t b;
  } sample_pair_t;

  typedef struct packed {
    adc_code_t a;
    adc_code_t b;
  } code_pair_t;

  // full scale limits
  localparam sample_t SAMPLE_MAX = sample_t'(8191);
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);

endpackage

`default_nettype wire

/* src/sys_bus_decoder.sv */
/*
  splits the system bus into 8 regions on addr[22:20]
  fully combinational, so slave timing passes straight through
  unused regions ack at once with zero data
*/
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder
  import sys_bus_pkg::*;
(
  input  wire sys_req_t sys_req_i,  // from bus master
  input  wire sys_rsp_t hk_rsp_i,   // housekeeping slave
  input  wire sys_rsp_t rt_rsp_i,   // router slave
  output sys_rsp_t      sys_rsp_o,
  output sys_req_t      hk_req_o,
  output sys_req_t      rt_req_o
);

  region_t                region;
  logic [SYS_REGIONS-1:0] cs;  // one hot chip select

  assign region = sys_req_i.addr[REGION_MSB:REGION_LSB];
  assign cs     = {{(SYS_REGIONS-1){1'b0}}, 1'b1} << region;

  ////////////////////////////////////////
  // request fan out
  ////////////////////////////////////////
  always_comb
  begin
    hk_req_o     = sys_req_i;                        // addr and data to all
    hk_req_o.wen = sys_req_i.wen & cs[HK_REGION];    // strobes only to the hit
    hk_req_o.ren = sys_req_i.ren & cs[HK_REGION];
  end

  always_comb
  begin
    rt_req_o     = sys_req_i;
    rt_req_o.wen = sys_req_i.wen & cs[ROUTER_REGION];
    rt_req_o.ren = sys_req_i.ren & cs[ROUTER_REGION];
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////
  always_comb
  begin
    // stub answer for empty regions
    sys_rsp_o.rdata = 32'h0;
    sys_rsp_o.err   = 1'b0;
    sys_rsp_o.ack   = 1'b1;
    case (region)
      HK_REGION:     sys_rsp_o = hk_rsp_i;
      ROUTER_REGION: sys_rsp_o = rt_rsp_i;
      default:       ;  // regions 1, 2, 4 to 7 keep the stub
    endcase
  end

endmodule

`default_nettype wire

/* src/housekeeping.sv */
/*
  board housekeeping registers in region 0
  id is read only, writes to it are dropped without error
  ack one cycle after the enable, other offsets answer with err
*/
`timescale 1ns/1ns
`default_nettype none

module housekeeping
  import sys_bus_pkg::*;
#(
  parameter logic [31:0] DESIGN_ID = 32'h0
)
(
  input  wire logic     adc_clk,
  input  wire logic     rst_n_i,
  input  wire sys_req_t req_i,
  output sys_rsp_t      rsp_o,
  output logic          digital_loop_o,  // dac samples back into adc path
  output logic [7:0]    led_o
);

  offset_t     offs;
  logic        access;
  logic        hit;      // offset is mapped
  logic [31:0] rd_val;
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign offs   = req_i.addr[REGION_LSB-1:0];
  assign access = req_i.wen | req_i.ren;

  // read mux, unused bits stay zero
  always_comb
  begin
    hit    = 1'b1;
    rd_val = 32'h0;
    case (offs)
      HK_ID_ADDR:   rd_val = DESIGN_ID;
      HK_LOOP_ADDR: rd_val = {31'h0, digital_loop_o};
      HK_LED_ADDR:  rd_val = {24'h0, led_o};
      default:      hit    = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q          <= 1'b0;
      err_q          <= 1'b0;
      digital_loop_o <= 1'b0;  // loopback off
      led_o          <= 8'h0;
    end
    else
    begin
      ack_q <= access;  // single cycle ack
      err_q <= access & ~hit;
      if (req_i.wen)
      begin
        if (offs == HK_LOOP_ADDR) digital_loop_o <= req_i.wdata[0];
        if (offs == HK_LED_ADDR)  led_o          <= req_i.wdata[7:0];
      end
    end
  end

  always_ff @(posedge adc_clk)
    rdata_q <= req_i.ren ? rd_val : 32'h0;  // zero on writes

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;
  assign rsp_o.ack   = ack_q;

endmodule

`default_nettype wire

/* src/analog_io.sv */
/*
  adc input register, loopback mux and dac output register
  converter codes are negative slope, msb kept and the rest inverted
  one cycle on the adc side, one cycle on the dac side
*/
`timescale 1ns/1ns
`default_nettype none

module analog_io
  import analog_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire code_pair_t   adc_code_i,      // raw adc pins
  input  wire logic         digital_loop_i,  // from housekeeping
  input  wire sample_pair_t dac_i,           // router output
  output sample_pair_t      adc_o,           // samples to the router
  output code_pair_t        dac_code_o       // dac pins
);

  // dac code for a zero sample
  localparam adc_code_t CODE_ZERO = {1'b0, {(ADC_BITS-1){1'b1}}};

  code_pair_t   adc_raw_q;
  sample_pair_t adc_conv;

  // negative slope code to two's complement
  function automatic sample_t code_to_sample(adc_code_t code);
    return sample_t'({code[ADC_BITS-1], ~code[ADC_BITS-2:0]});
  endfunction

  // and back again, same bit flip
  function automatic adc_code_t sample_to_code(sample_t smp);
    return {smp[ADC_BITS-1], ~smp[ADC_BITS-2:0]};
  endfunction

  ////////////////////////////////////////
  // adc side
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
    adc_raw_q <= adc_code_i;  // io register

  assign adc_conv.a = code_to_sample(adc_raw_q.a);
  assign adc_conv.b = code_to_sample(adc_raw_q.b);

  // loopback replaces the adc samples with what goes to the dac
  assign adc_o = digital_loop_i ? dac_i : adc_conv;

  ////////////////////////////////////////
  // dac side
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_code_o.a <= CODE_ZERO;  // mid scale
      dac_code_o.b <= CODE_ZERO;
    end
    else
    begin
      dac_code_o.a <= sample_to_code(dac_i.a);
      dac_code_o.b <= sample_to_code(dac_i.b);
    end
  end

endmodule

`default_nettype wire

/* src/signal_router.sv */
/*
  two channel signal router in region 3
  per channel source is adc or a static value, plus an offset
  sum is saturated to the 14 bit range and registered once
*/
`timescale 1ns/1ns
`default_nettype none

module signal_router
  import sys_bus_pkg::*;
  import analog_pkg::*;
(
  input  wire logic         adc_clk,
  input  wire logic         rst_n_i,
  input  wire sys_req_t     req_i,
  input  wire sample_pair_t adc_i,  // adc side samples
  output sys_rsp_t          rsp_o,
  output sample_pair_t      dac_o   // to the dac register
);

  // one channel worth of settings
  typedef struct packed {
    logic    src_static;  // 1 selects static value
    sample_t static_val;
    sample_t offset;
  } ch_cfg_t;

  ch_cfg_t     cfg_a_q;
  ch_cfg_t     cfg_b_q;
  offset_t     offs;
  logic        access;
  logic        hit;
  logic [31:0] rd_val;
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // sign extend to bus width
  function automatic logic [31:0] sext(sample_t smp);
    return {{(32-ADC_BITS){smp[ADC_BITS-1]}}, smp};
  endfunction

  // add at one extra bit then clamp
  function automatic sample_t sat_add(sample_t x, sample_t k);
    logic signed [ADC_BITS:0] sum;
    sample_t                  res;
    sum = x + k;
    if (sum > SAMPLE_MAX)
      res = SAMPLE_MAX;
    else if (sum < SAMPLE_MIN)
      res = SAMPLE_MIN;
    else
      res = sample_t'(sum);
    return res;
  endfunction

  function automatic sample_t route(ch_cfg_t cfg, sample_t adc);
    return sat_add(cfg.src_static ? cfg.static_val : adc, cfg.offset);
  endfunction

  ////////////////////////////////////////
  // bus registers
  ////////////////////////////////////////
  assign offs   = req_i.addr[REGION_LSB-1:0];
  assign access = req_i.wen | req_i.ren;

  always_comb
  begin
    hit    = 1'b1;
    rd_val = 32'h0;
    case (offs)
      RT_CFG_A_ADDR:    rd_val = {31'h0, cfg_a_q.src_static};
      RT_STATIC_A_ADDR: rd_val = sext(cfg_a_q.static_val);
      RT_OFFSET_A_ADDR: rd_val = sext(cfg_a_q.offset);
      RT_CFG_B_ADDR:    rd_val = {31'h0, cfg_b_q.src_static};
      RT_STATIC_B_ADDR: rd_val = sext(cfg_b_q.static_val);
      RT_OFFSET_B_ADDR: rd_val = sext(cfg_b_q.offset);
      default:          hit    = 1'b0;  // answered with err
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      cfg_a_q <= '0;  // adc source, zero static and offset
      cfg_b_q <= '0;
    end
    else
    begin
      ack_q <= access;
      err_q <= access & ~hit;
      if (req_i.wen)
      begin
        case (offs)
          RT_CFG_A_ADDR:    cfg_a_q.src_static <= req_i.wdata[0];
          RT_STATIC_A_ADDR: cfg_a_q.static_val <= sample_t'(req_i.wdata[ADC_BITS-1:0]);
          RT_OFFSET_A_ADDR: cfg_a_q.offset     <= sample_t'(req_i.wdata[ADC_BITS-1:0]);
          RT_CFG_B_ADDR:    cfg_b_q.src_static <= req_i.wdata[0];
          RT_STATIC_B_ADDR: cfg_b_q.static_val <= sample_t'(req_i.wdata[ADC_BITS-1:0]);
          RT_OFFSET_B_ADDR: cfg_b_q.offset     <= sample_t'(req_i.wdata[ADC_BITS-1:0]);
          default:          ;  // unmapped, nothing stored
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
    rdata_q <= req_i.ren ? rd_val : 32'h0;

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;
  assign rsp_o.ack   = ack_q;

  ////////////////////////////////////////
  // sample path
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_o <= '0;  // zero output out of reset
    else
    begin
      dac_o.a <= route(cfg_a_q, adc_i.a);
      dac_o.b <= route(cfg_b_q, adc_i.b);
    end
  end

endmodule

`default_nettype wire

/* src/rp_top.sv */
/*
  top level of the analog path and control bus, single clock adc_clk
  the bus master sits outside and drives sys_req_i directly
  adc pin to dac pin latency is 3 cycles
*/
`timescale 1ns/1ns
`default_nettype none

module rp_top
  import sys_bus_pkg::*;
  import analog_pkg::*;
#(
  parameter logic [31:0] DESIGN_ID = 32'h5250_0001  // read back from hk id
)
(
  input  wire logic      adc_clk,
  input  wire logic      rst_n_i,
  input  wire sys_req_t  sys_req_i,
  output sys_rsp_t       sys_rsp_o,
  input  wire adc_code_t adc_dat_a_i,  // adc ch1
  input  wire adc_code_t adc_dat_b_i,  // adc ch2
  output adc_code_t      dac_dat_a_o,  // dac ch1
  output adc_code_t      dac_dat_b_o,  // dac ch2
  output logic [7:0]     led_o
);

  sys_req_t     hk_req;
  sys_req_t     rt_req;
  sys_rsp_t     hk_rsp;
  sys_rsp_t     rt_rsp;
  logic         digital_loop;
  sample_pair_t adc_smp;    // adc side into router
  sample_pair_t dac_smp;    // router out to dac side
  code_pair_t   adc_codes;
  code_pair_t   dac_codes;

  // pins to and from channel pairs
  assign adc_codes.a = adc_dat_a_i;
  assign adc_codes.b = adc_dat_b_i;
  assign dac_dat_a_o = dac_codes.a;
  assign dac_dat_b_o = dac_codes.b;

  sys_bus_decoder i_dec (
    .sys_req_i (sys_req_i),
    .hk_rsp_i  (hk_rsp),
    .rt_rsp_i  (rt_rsp),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .rt_req_o  (rt_req)
  );

  housekeeping #(.DESIGN_ID(DESIGN_ID)) i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  signal_router i_router (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (rt_req),
    .adc_i   (adc_smp),
    .rsp_o   (rt_rsp),
    .dac_o   (dac_smp)
  );

  analog_io i_analog (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_code_i     (adc_codes),
    .digital_loop_i (digital_loop),
    .dac_i          (dac_smp),
    .adc_o          (adc_smp),
    .dac_code_o     (dac_codes)
  );

endmodule

`default_nettype wire

/* tests/tb_bus_tasks.svh */
/*
  bus access task, random source and converter model for tb_rp_top
  included inside the testbench module, uses its signals directly
  the bus task waits at most 4 cycles for ack
*/
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// 32 bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
task automatic rand_bits(input int n, output logic [31:0] v);
  v = 32'h0;
  for (int i = 0; i < n; i++)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
endtask

////////////////////////////////////////
// converter model
////////////////////////////////////////
function automatic int code_val(logic [13:0] c);
  int v;
  v = int'(c ^ 14'h1fff);  // negative slope, msb kept
  if (v >= 8192)
    v = v - 16384;
  return v;
endfunction

function automatic int reg_val(logic [13:0] r);  // 14 bit register as signed
  return r[13] ? int'(r) - 16384 : int'(r);
endfunction

function automatic logic [13:0] expect_code(int src, int off);
  int s;
  logic [31:0] w;
  s = src + off;
  if (s > 8191)
    s = 8191;
  if (s < -8192)
    s = -8192;
  w = s;
  return w[13:0] ^ 14'h1fff;
endfunction

// one access, enable held a single cycle, addr held until ack
task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
  int   waited;
  logic ok;
  waited = 0;
  ok     = 1'b0;
  rdata  = 32'h0;
  err    = 1'b0;
  @(negedge adc_clk);
  sys_req.addr  = addr;
  sys_req.wdata = wdata;
  sys_req.sel   = 4'hf;
  sys_req.wen   = wr;
  sys_req.ren   = !wr;
  #1;
  if (sys_rsp.ack)  // empty regions answer at once
  begin
    ok    = 1'b1;
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
  end
  while (!ok && waited < 4)
  begin
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    waited++;
    if (sys_rsp.ack)
    begin
      ok    = 1'b1;
      rdata = sys_rsp.rdata;
      err   = sys_rsp.err;
    end
  end
  if (sys_req.wen || sys_req.ren)
  begin
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
  end
  if (!ok)
  begin
    $display("no ack from the bus for address %h within 4 cycles", addr);
    errors++;
  end
endtask

`endif

/* tests/tb_rp_top.sv */
/*
  testbench for rp_top, bus table then random and loopback sample tests
  inputs change on the falling edge, outputs are checked there too
*/
`timescale 1ns/1ns
`default_nettype none

module tb_rp_top
  import sys_bus_pkg::*;
  import analog_pkg::*;
;
  localparam logic [31:0] ID = 32'h1c3a_5e07;
  localparam logic [31:0] RT = 32'h0030_0000;  // router region base

  typedef enum {OP_WR, OP_RD, OP_LED, OP_SMP} op_t;
  typedef struct {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [13:0] adc_a;
    logic [13:0] adc_b;
    logic [13:0] exp_a;
    logic [13:0] exp_b;
  } row_t;

  logic        adc_clk = 1'b0;
  logic        rst_n;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  adc_code_t   adc_dat_a;
  adc_code_t   adc_dat_b;
  adc_code_t   dac_dat_a;
  adc_code_t   dac_dat_b;
  logic [7:0]  led;
  logic [31:0] lfsr_state = 32'hbaf9db70;
  int          errors = 0;
  int          test_errors;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          cycle_limit = 100000;
  row_t        rows[$];

  `include "tb_bus_tasks.svh"

  rp_top #(.DESIGN_ID(ID)) UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .led_o       (led)
  );

  always #4 adc_clk = ~adc_clk;  // 8 ns

  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("run stopped, no end after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic add_row(op_t op, logic [31:0] addr, logic [31:0] data, logic [31:0] exp_rdata,
                         logic exp_err, logic [13:0] ea = 0, logic [13:0] eb = 0);
    row_t r;
    r = '{op, addr, data, exp_rdata, exp_err, 14'h0abc, 14'h2345, ea, eb};
    rows.push_back(r);
  endtask

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: %0d errors", name, errors - test_errors);
      tests_failed++;
    end
  endtask

  // random adc codes on both channels, adc source, checked 3 cycles later
  task automatic stream_check(input int n, input int off_a, input int off_b);
    logic [13:0] exp_a[$];
    logic [13:0] exp_b[$];
    logic [31:0] r;
    for (int i = 0; i < n + 3; i++)
    begin
      @(negedge adc_clk);
      if (i >= 3)
      begin
        check_val("dac_dat_a_o", dac_dat_a, exp_a.pop_front());
        check_val("dac_dat_b_o", dac_dat_b, exp_b.pop_front());
      end
      if (i < n)
      begin
        rand_bits(14, r);
        adc_dat_a = r[13:0];
        rand_bits(14, r);
        adc_dat_b = r[13:0];
        exp_a.push_back(expect_code(code_val(adc_dat_a), off_a));
        exp_b.push_back(expect_code(code_val(adc_dat_b), off_b));
      end
    end
  endtask

  task automatic apply_table();
    logic [31:0] rd;
    logic        er;
    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_WR, OP_RD:
        begin
          bus_access(rows[i].op == OP_WR, rows[i].addr, rows[i].data, rd, er);
          if (rows[i].op == OP_RD)
            check_val("sys_rsp_o.rdata", rd, rows[i].exp_rdata);
          check_val("sys_rsp_o.err", {31'h0, er}, {31'h0, rows[i].exp_err});
        end
        OP_LED: check_val("led_o", {24'h0, led}, rows[i].data);
        OP_SMP:
        begin
          @(negedge adc_clk);
          adc_dat_a = rows[i].adc_a;
          adc_dat_b = rows[i].adc_b;
          repeat (3) @(negedge adc_clk);
          check_val("dac_dat_a_o", dac_dat_a, rows[i].exp_a);
          check_val("dac_dat_b_o", dac_dat_b, rows[i].exp_b);
        end
      endcase
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] rd;
    logic        er;
    int          off_a;
    int          off_b;
    rst_n     = 1'b0;
    sys_req   = '0;
    adc_dat_a = 14'h1fff;
    adc_dat_b = 14'h1fff;

    ////////////////////////////////////////
    // bus and static source table
    ////////////////////////////////////////
    add_row(OP_RD, 32'h0, 0, ID, 0);
    add_row(OP_WR, 32'h0, 32'hdead_beef, 0, 0);  // id stays put
    add_row(OP_RD, 32'h0, 0, ID, 0);
    add_row(OP_WR, 32'h8, 32'ha5, 0, 0);
    add_row(OP_LED, 0, 32'ha5, 0, 0);
    add_row(OP_RD, 32'h8, 0, 32'ha5, 0);
    for (int g = 1; g < 8; g++)
      if (g != 3)
        add_row(OP_RD, g << 20, 0, 0, 0);
    add_row(OP_RD, 32'h0c, 0, 0, 1);
    add_row(OP_RD, RT + 32'h0c, 0, 0, 1);
    add_row(OP_WR, RT + 32'h04, 32'h3448, 0, 0);  // -3000
    add_row(OP_RD, RT + 32'h04, 0, 32'hffff_f448, 0);
    add_row(OP_WR, RT + 32'h18, 32'h1234, 0, 0);
    add_row(OP_RD, RT + 32'h18, 0, 32'h1234, 0);
    // static sources driven into both clamps
    add_row(OP_WR, RT + 32'h00, 1, 0, 0);
    add_row(OP_WR, RT + 32'h04, 32'h1f40, 0, 0);  // 8000
    add_row(OP_WR, RT + 32'h08, 32'h01f4, 0, 0);  // 500
    add_row(OP_WR, RT + 32'h10, 1, 0, 0);
    add_row(OP_WR, RT + 32'h14, 32'h20c0, 0, 0);  // -8000
    add_row(OP_WR, RT + 32'h18, 32'h3e0c, 0, 0);  // -500
    add_row(OP_RD, RT + 32'h10, 0, 1, 0);
    add_row(OP_SMP, 0, 0, 0, 0, 14'h0000, 14'h3fff);
    add_row(OP_WR, RT + 32'h04, 32'h0064, 0, 0);  // 100
    add_row(OP_WR, RT + 32'h08, 32'h3fce, 0, 0);  // -50
    add_row(OP_WR, RT + 32'h14, 32'h1234, 0, 0);
    add_row(OP_SMP, 0, 0, 0, 0, expect_code(100, -50), expect_code(reg_val(14'h1234), -500));
    add_row(OP_WR, RT + 32'h00, 0, 0, 0);
    add_row(OP_WR, RT + 32'h10, 0, 0, 0);
    cycle_limit = rows.size() * 10 + 40 * 4 + 100;

    repeat (2) @(negedge adc_clk);
    rst_n = 1'b1;

    start_test();
    check_val("dac_dat_a_o", dac_dat_a, 14'h1fff);
    check_val("dac_dat_b_o", dac_dat_b, 14'h1fff);
    check_val("led_o", {24'h0, led}, 0);
    check_val("sys_rsp_o.ack", {31'h0, sys_rsp.ack}, 0);
    end_test("reset state");

    start_test();
    apply_table();
    end_test("bus and static table");

    // random offsets, one block of samples each, then zero offset
    start_test();
    for (int k = 0; k < 4; k++)
    begin
      rand_bits(14, r);
      off_a = reg_val(r[13:0]);
      bus_access(1, RT + 32'h08, r, rd, er);
      rand_bits(14, r);
      off_b = reg_val(r[13:0]);
      bus_access(1, RT + 32'h18, r, rd, er);
      if (k == 3)
      begin
        off_a = 0;
        off_b = 0;
        bus_access(1, RT + 32'h08, 0, rd, er);
        bus_access(1, RT + 32'h18, 0, rd, er);
      end
      stream_check(8, off_a, off_b);
    end
    end_test("adc passthrough");

    ////////////////////////////////////////
    // digital loopback on channel a
    ////////////////////////////////////////
    start_test();
    bus_access(1, RT + 32'h08, 32'h03e8, rd, er);  // +1000
    bus_access(1, 32'h04, 1, rd, er);
    bus_access(0, 32'h04, 0, rd, er);
    check_val("sys_rsp_o.rdata", rd, 1);  // loop bit reads back
    repeat (20) @(negedge adc_clk);
    check_val("dac_dat_a_o", dac_dat_a, 14'h0000);
    bus_access(1, RT + 32'h08, 32'h3c18, rd, er);  // -1000
    repeat (20) @(negedge adc_clk);
    check_val("dac_dat_a_o", dac_dat_a, 14'h3fff);
    bus_access(1, 32'h04, 0, rd, er);
    bus_access(1, RT + 32'h08, 0, rd, er);
    stream_check(8, 0, 0);
    end_test("digital loopback");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+tests
src/sys_bus_pkg.sv
src/analog_pkg.sv
src/sys_bus_decoder.sv
src/housekeeping.sv
src/analog_io.sv
src/signal_router.sv
src/rp_top.sv
tests/tb_rp_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rp_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_rp_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_rp_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulator returned status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
